/* dv/mipsProgramTable.svh */
// instruction encoders, program words, expected write-back and store events
`ifndef MIPS_PROGRAM_TABLE_SVH
`define MIPS_PROGRAM_TABLE_SVH

// program rows hold one instruction word each
// retire rows are valid, register, value; store rows are address, data, read, write

function automatic word_t rType(input funct_t fn, input int rd, input int rs, input int rt);
    return {opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic word_t iType(input opcode_t op, input int rt, input int rs, input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

localparam int progLen = 22;

localparam word_t progWords [progLen] = '{
    iType(opAddi, 1, 0, 5),
    iType(opAddi, 2, 0, -3),
    rType(fnAdd, 3, 1, 2),
    rType(fnSub, 4, 3, 1),
    rType(fnAnd, 5, 4, 1),
    rType(fnOr, 6, 5, 2),
    rType(fnSlt, 7, 2, 1),
    rType(fnSlt, 8, 1, 2),
    iType(opAddi, 9, 0, 'h40),
    iType(opAddi, 10, 0, 'h77),
    // store data and base both forwarded
    iType(opSw, 10, 9, 4),
    iType(opLw, 11, 9, 4),
    // uses the load result right away
    rType(fnAdd, 12, 11, 1),
    // taken, lands on word 16
    iType(opBeq, 12, 12, 2),
    iType(opAddi, 13, 0, 'h99),
    iType(opSw, 1, 9, 0),
    // 5 vs -3, falls through
    iType(opBeq, 2, 1, 3),
    iType(opAddi, 0, 0, 'h55),
    rType(fnAdd, 14, 0, 0),
    iType(opSw, 12, 9, 0),
    iType(opLw, 15, 9, 0),
    rType(fnSub, 16, 15, 12)
};

localparam int numRetires = 16;

localparam retire_t expRetires [numRetires] = '{
    '{1'b1, 5'd1, 32'h0000_0005},
    '{1'b1, 5'd2, 32'hffff_fffd},
    '{1'b1, 5'd3, 32'h0000_0002},
    '{1'b1, 5'd4, 32'hffff_fffd},
    '{1'b1, 5'd5, 32'h0000_0005},
    '{1'b1, 5'd6, 32'hffff_fffd},
    '{1'b1, 5'd7, 32'h0000_0001},
    '{1'b1, 5'd8, 32'h0000_0000},
    '{1'b1, 5'd9, 32'h0000_0040},
    '{1'b1, 5'd10, 32'h0000_0077},
    '{1'b1, 5'd11, 32'h0000_0077},
    '{1'b1, 5'd12, 32'h0000_007c},
    '{1'b1, 5'd0, 32'h0000_0055},
    '{1'b1, 5'd14, 32'h0000_0000},
    '{1'b1, 5'd15, 32'h0000_007c},
    '{1'b1, 5'd16, 32'h0000_0000}
};

localparam int numStores = 2;

localparam dmemReq_t expStores [numStores] = '{
    '{32'h0000_0044, 32'h0000_0077, 1'b0, 1'b1},
    '{32'h0000_0040, 32'h0000_007c, 1'b0, 1'b1}
};

`endif

/* dv/mipsPipelineTb.sv */
// testbench for the MIPS pipeline with memory models, retire and store checks, timeout
`timescale 1ns/1ps
`default_nettype none

module mipsPipelineTb;
    import mipsPkg::*;

    `include "mipsProgramTable.svh"

    localparam word_t resetPc = 32'h0000_0100;
    localparam int resetCycles = 8;
    localparam int drainCycles = 8;
    localparam int cycleLimit = 4 * progLen + 20;

    logic     clk = 1'b0;
    logic     rstN = 1'b0;
    word_t    imemAddr;
    word_t    imemData;
    dmemReq_t dmemReq;
    word_t    dmemRdata;
    retire_t  retire;

    word_t imem [progLen];
    word_t dmem [64];
    word_t fetchOffset;
    int    cycleCount = 0;
    int    storeIdx = 0;
    int    valueErrors = 0;
    int    eventErrors = 0;

    mipsPipeline #(.resetPc(resetPc)) mipsPipeline_inst (
        .clk(clk),
        .rstN(rstN),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .dmemReq(dmemReq),
        .dmemRdata(dmemRdata),
        .retire(retire)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (rstN) begin
            cycleCount <= cycleCount + 1;
        end
    end

    // every bit of the address shows in the word
    function automatic word_t fillWord(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'ha5a5_5a5a;
    endfunction

    initial begin
        for (int i = 0; i < progLen; i++) begin
            imem[i] = progWords[i];
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fillWord(32'(i * 4));
        end
    end

    // outside the program the fetch sees all-zero words
    always_comb begin
        fetchOffset = imemAddr - resetPc;
        if (fetchOffset[31:2] < progLen) begin
            imemData = imem[fetchOffset[31:2]];
        end else begin
            imemData = '0;
        end
    end

    always_comb begin
        if (dmemReq.addr[31:8] == '0) begin
            dmemRdata = dmem[dmemReq.addr[7:2]];
        end else begin
            dmemRdata = fillWord(dmemReq.addr);
        end
    end

    always @(posedge clk) begin
        if (dmemReq.write && dmemReq.addr[31:8] == '0) begin
            dmem[dmemReq.addr[7:2]] <= dmemReq.wdata;
        end
    end

    task automatic checkRetire(input int idx, input retire_t got, input retire_t exp);
        if (got.addr !== exp.addr) begin
            $display("[FAIL] retire.addr event %0d got %h expected %h", idx, got.addr, exp.addr);
            valueErrors++;
        end
        if (got.value !== exp.value) begin
            $display("[FAIL] retire.value event %0d got %h expected %h",
                     idx, got.value, exp.value);
            valueErrors++;
        end
    endtask

    task automatic checkStore(input int idx, input dmemReq_t got, input dmemReq_t exp);
        if (got.addr !== exp.addr) begin
            $display("[FAIL] dmemReq.addr store %0d got %h expected %h", idx, got.addr, exp.addr);
            valueErrors++;
        end
        if (got.wdata !== exp.wdata) begin
            $display("[FAIL] dmemReq.wdata store %0d got %h expected %h",
                     idx, got.wdata, exp.wdata);
            valueErrors++;
        end
        if (got.read !== exp.read) begin
            $display("[FAIL] dmemReq.read store %0d got %h expected %h",
                     idx, got.read, exp.read);
            valueErrors++;
        end
    endtask

    task automatic quietCheck(input retire_t r, input dmemReq_t d);
        if (r.valid !== 1'b0) begin
            $display("[FAIL] retire.valid got %h expected 0", r.valid);
            valueErrors++;
        end
        if (d.write !== 1'b0 || d.read !== 1'b0) begin
            $display("[FAIL] dmemReq strobes got %h expected 0", {d.read, d.write});
            valueErrors++;
        end
    endtask

    task automatic fetchAddrCheck(input word_t got);
        if (got !== resetPc) begin
            $display("[FAIL] imemAddr got %h expected %h", got, resetPc);
            valueErrors++;
        end
    endtask

    // bounded by the cycle counter
    task automatic waitRetire(output logic seen);
        seen = 1'b0;
        while (!seen && cycleCount < cycleLimit) begin
            @(negedge clk);
            if (retire.valid === 1'b1) begin
                seen = 1'b1;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rstN && dmemReq.write === 1'b1) begin
            if (storeIdx < numStores) begin
                checkStore(storeIdx, dmemReq, expStores[storeIdx]);
            end else begin
                $display("unexpected store to address %h after all expected stores",
                         dmemReq.addr);
                eventErrors++;
            end
            storeIdx++;
        end
    end

    initial begin
        logic seen;
        logic timedOut;
        timedOut = 1'b0;
        repeat (resetCycles) begin
            @(posedge clk);
            #1;
            quietCheck(retire, dmemReq);
            fetchAddrCheck(imemAddr);
        end
        rstN = 1'b1;
        @(negedge clk);
        quietCheck(retire, dmemReq);
        fetchAddrCheck(imemAddr);

        for (int i = 0; i < numRetires && !timedOut; i++) begin
            waitRetire(seen);
            if (seen) begin
                checkRetire(i, retire, expRetires[i]);
            end else begin
                $display("timeout: retire event %0d not seen within %0d cycles", i, cycleLimit);
                eventErrors++;
                timedOut = 1'b1;
            end
        end

        // flushed or stray instructions would show up here
        if (!timedOut) begin
            repeat (drainCycles) begin
                @(negedge clk);
                if (retire.valid === 1'b1) begin
                    $display("unexpected retire of register %0d after the last expected one",
                             retire.addr);
                    eventErrors++;
                end
            end
        end
        if (storeIdx < numStores) begin
            $display("only %0d of %0d expected stores were seen", storeIdx, numStores);
            eventErrors++;
        end

        $display("error counts: %0d wrong values, %0d missing or unexpected events",
                 valueErrors, eventErrors);
        if (valueErrors == 0 && eventErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+dv
verilog/mipsPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/mipsPipeline.sv
dv/mipsPipelineTb.sv

/* verilog/decodeStage.sv */
// control decode, immediate extension, branch target and ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire  mipsPkg::instr_t  ifInstr,
    input  wire  mipsPkg::word_t   ifPcNext,
    input  wire  mipsPkg::word_t   rsData,
    input  wire  mipsPkg::word_t   rtData,
    input  wire                    stall,
    input  wire                    flush,
    output mipsPkg::idEx_t         idEx
);
    import mipsPkg::*;

    ctrl_t ctrl;
    word_t immExt;
    idEx_t idExD;
    ctrl_t ctrlQ;
    idEx_t payloadQ;
    logic  bubble;

    // R-type operation is picked from funct in EX
    always_comb begin
        ctrl = '0;
        ctrl.aluOp = aluAdd;
        case (ifInstr.i.opcode)
            opSpecial: begin
                ctrl.regDstRd = 1'b1;
                case (ifInstr.r.funct)
                    fnAdd, fnSub, fnAnd, fnOr, fnSlt: ctrl.regWrite = 1'b1;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            opAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp = aluSub;
            end
            default: ctrl = '0;
        endcase
    end

    assign immExt = {{(dataWidth-16){ifInstr.i.imm16[15]}}, ifInstr.i.imm16};

    always_comb begin
        idExD.ctrl = ctrl;
        idExD.rs = ifInstr.r.rs;
        idExD.rt = ifInstr.r.rt;
        idExD.dst = ctrl.regDstRd ? ifInstr.r.rd : ifInstr.i.rt;
        idExD.rsData = rsData;
        idExD.rtData = rtData;
        idExD.imm = immExt;
        // word offset relative to the next sequential PC
        idExD.branchTarget = ifPcNext + (immExt << 2);
    end

    assign bubble = stall || flush;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlQ <= '0;
        end else if (bubble) begin
            ctrlQ <= '0;
        end else begin
            ctrlQ <= idExD.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        payloadQ <= idExD;
    end

    always_comb begin
        idEx = payloadQ;
        idEx.ctrl = ctrlQ;
    end

endmodule

`default_nettype wire

/* verilog/executeStage.sv */
// ALU control, ALU, operand forwarding, beq resolution and EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire  mipsPkg::idEx_t   idEx,
    input  wire  mipsPkg::fwdSel_t fwdA,
    input  wire  mipsPkg::fwdSel_t fwdB,
    input  wire  mipsPkg::word_t   exMemFwd,
    input  wire  mipsPkg::word_t   wbFwd,
    output mipsPkg::exMem_t        exMem,
    output logic                   branchTaken,
    output mipsPkg::word_t         branchTarget
);
    import mipsPkg::*;

    word_t  opA;
    word_t  opB;
    word_t  aluB;
    word_t  aluResult;
    aluOp_t aluSel;
    exMem_t exMemD;
    exMem_t payloadQ;
    logic   regWriteQ;
    logic   memReadQ;
    logic   memWriteQ;

    always_comb begin
        case (fwdA)
            fwdExMem: opA = exMemFwd;
            fwdMemWb: opA = wbFwd;
            default:  opA = idEx.rsData;
        endcase
        case (fwdB)
            fwdExMem: opB = exMemFwd;
            fwdMemWb: opB = wbFwd;
            default:  opB = idEx.rtData;
        endcase
    end

    assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

    // R-type funct sits in the low bits of the immediate field
    always_comb begin
        aluSel = idEx.ctrl.aluOp;
        if (idEx.ctrl.regDstRd) begin
            case (funct_t'(idEx.imm[5:0]))
                fnSub:   aluSel = aluSub;
                fnAnd:   aluSel = aluAnd;
                fnOr:    aluSel = aluOr;
                fnSlt:   aluSel = aluSlt;
                default: aluSel = aluAdd;
            endcase
        end
    end

    always_comb begin
        case (aluSel)
            aluSub:  aluResult = opA - aluB;
            aluAnd:  aluResult = opA & aluB;
            aluOr:   aluResult = opA | aluB;
            aluSlt:  aluResult = {{(dataWidth-1){1'b0}}, $signed(opA) < $signed(aluB)};
            default: aluResult = opA + aluB;
        endcase
    end

    // beq compares forwarded operands directly
    assign branchTaken = idEx.ctrl.branch && (opA == opB);
    assign branchTarget = idEx.branchTarget;

    always_comb begin
        exMemD.regWrite = idEx.ctrl.regWrite;
        exMemD.memRead = idEx.ctrl.memRead;
        exMemD.memWrite = idEx.ctrl.memWrite;
        exMemD.aluResult = aluResult;
        exMemD.storeData = opB;
        exMemD.dst = idEx.dst;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteQ <= 1'b0;
            memReadQ <= 1'b0;
            memWriteQ <= 1'b0;
        end else begin
            regWriteQ <= exMemD.regWrite;
            memReadQ <= exMemD.memRead;
            memWriteQ <= exMemD.memWrite;
        end
    end

    always_ff @(posedge clk) begin
        payloadQ <= exMemD;
    end

    always_comb begin
        exMem = payloadQ;
        exMem.regWrite = regWriteQ;
        exMem.memRead = memReadQ;
        exMem.memWrite = memWriteQ;
    end

endmodule

`default_nettype wire

/* verilog/fetchStage.sv */
// program counter, next-PC select and IF/ID register
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter mipsPkg::word_t resetPc = '0
) (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire                    stall,
    input  wire                    branchTaken,
    input  wire  mipsPkg::word_t   branchTarget,
    input  wire  mipsPkg::word_t   imemData,
    output mipsPkg::word_t         imemAddr,
    output mipsPkg::instr_t        ifInstr,
    output mipsPkg::word_t         ifPcNext
);
    import mipsPkg::*;

    word_t pc;
    word_t pcPlus4;

    assign pcPlus4 = pc + 32'd4;
    assign imemAddr = pc;

    // a taken branch wins over a stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall) begin
            pc <= pcPlus4;
        end
    end

    // all-zero word decodes to no controls
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifInstr <= '0;
        end else if (branchTaken) begin
            ifInstr <= '0;
        end else if (!stall) begin
            ifInstr <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifPcNext <= pcPlus4;
        end
    end

endmodule

`default_nettype wire

/* verilog/hazardUnit.sv */
// forwarding selects, load-use stall and flush control
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire  mipsPkg::instr_t  ifInstr,
    input  wire  mipsPkg::idEx_t   idEx,
    input  wire  mipsPkg::exMem_t  exMem,
    input  wire  mipsPkg::memWb_t  memWb,
    input  wire                    branchTaken,
    output logic                   stall,
    output logic                   flush,
    output mipsPkg::fwdSel_t       fwdA,
    output mipsPkg::fwdSel_t       fwdB
);
    import mipsPkg::*;

    // newest producer first, r0 never forwarded
    function automatic fwdSel_t pickSource(input regAddr_t src);
        fwdSel_t sel;
        if (exMem.regWrite && exMem.dst != '0 && exMem.dst == src) begin
            sel = fwdExMem;
        end else if (memWb.regWrite && memWb.dst != '0 && memWb.dst == src) begin
            sel = fwdMemWb;
        end else begin
            sel = fwdReg;
        end
        return sel;
    endfunction

    assign fwdA = pickSource(idEx.rs);
    assign fwdB = pickSource(idEx.rt);

    // rt compared for every format, an occasional extra stall is harmless
    assign stall = idEx.ctrl.memRead && idEx.dst != '0
                   && (idEx.dst == ifInstr.r.rs || idEx.dst == ifInstr.r.rt);

    assign flush = branchTaken || stall;

endmodule

`default_nettype wire

/* verilog/memWbStage.sv */
// data memory request, MEM/WB register and write-back select
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire  mipsPkg::exMem_t  exMem,
    input  wire  mipsPkg::word_t   dmemRdata,
    output mipsPkg::dmemReq_t      dmemReq,
    output mipsPkg::memWb_t        memWb,
    output mipsPkg::retire_t       retire,
    output mipsPkg::word_t         wbFwd
);
    import mipsPkg::*;

    memWb_t payloadQ;
    logic   regWriteQ;
    logic   memReadQ;

    // memory answers in the same cycle
    always_comb begin
        dmemReq.addr = exMem.aluResult;
        dmemReq.wdata = exMem.storeData;
        dmemReq.read = exMem.memRead;
        dmemReq.write = exMem.memWrite;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteQ <= 1'b0;
            memReadQ <= 1'b0;
        end else begin
            regWriteQ <= exMem.regWrite;
            memReadQ <= exMem.memRead;
        end
    end

    always_ff @(posedge clk) begin
        payloadQ.aluResult <= exMem.aluResult;
        payloadQ.loadData <= dmemRdata;
        payloadQ.dst <= exMem.dst;
    end

    always_comb begin
        memWb.regWrite = regWriteQ;
        memWb.memRead = memReadQ;
        memWb.aluResult = payloadQ.aluResult;
        memWb.loadData = payloadQ.loadData;
        memWb.dst = payloadQ.dst;
    end

    assign wbFwd = memWb.memRead ? memWb.loadData : memWb.aluResult;

    // every register write shows up here
    always_comb begin
        retire.valid = memWb.regWrite;
        retire.addr = memWb.dst;
        retire.value = wbFwd;
    end

endmodule

`default_nettype wire

/* verilog/mipsPipeline.sv */
// top of the five-stage MIPS pipeline with memory and retire ports
`timescale 1ns/1ps
`default_nettype none

module mipsPipeline #(
    parameter mipsPkg::word_t resetPc = '0
) (
    input  wire                    clk,
    input  wire                    rstN,
    output mipsPkg::word_t         imemAddr,
    input  wire  mipsPkg::word_t   imemData,
    output mipsPkg::dmemReq_t      dmemReq,
    input  wire  mipsPkg::word_t   dmemRdata,
    output mipsPkg::retire_t       retire
);
    import mipsPkg::*;

    instr_t  ifInstr;
    word_t   ifPcNext;
    word_t   rsData;
    word_t   rtData;
    idEx_t   idEx;
    exMem_t  exMem;
    memWb_t  memWb;
    word_t   wbFwd;
    logic    stall;
    logic    flush;
    logic    branchTaken;
    word_t   branchTarget;
    fwdSel_t fwdA;
    fwdSel_t fwdB;

    fetchStage #(.resetPc(resetPc)) fetchStage_inst (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .imemData(imemData),
        .imemAddr(imemAddr),
        .ifInstr(ifInstr),
        .ifPcNext(ifPcNext)
    );

    decodeStage decodeStage_inst (
        .clk(clk),
        .rstN(rstN),
        .ifInstr(ifInstr),
        .ifPcNext(ifPcNext),
        .rsData(rsData),
        .rtData(rtData),
        .stall(stall),
        .flush(flush),
        .idEx(idEx)
    );

    // read ports are addressed straight from IF/ID
    regFile regFile_inst (
        .clk(clk),
        .rstN(rstN),
        .rsAddr(ifInstr.r.rs),
        .rtAddr(ifInstr.r.rt),
        .wb(retire),
        .rsData(rsData),
        .rtData(rtData)
    );

    hazardUnit hazardUnit_inst (
        .ifInstr(ifInstr),
        .idEx(idEx),
        .exMem(exMem),
        .memWb(memWb),
        .branchTaken(branchTaken),
        .stall(stall),
        .flush(flush),
        .fwdA(fwdA),
        .fwdB(fwdB)
    );

    executeStage executeStage_inst (
        .clk(clk),
        .rstN(rstN),
        .idEx(idEx),
        .fwdA(fwdA),
        .fwdB(fwdB),
        .exMemFwd(exMem.aluResult),
        .wbFwd(wbFwd),
        .exMem(exMem),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    memWbStage memWbStage_inst (
        .clk(clk),
        .rstN(rstN),
        .exMem(exMem),
        .dmemRdata(dmemRdata),
        .dmemReq(dmemReq),
        .memWb(memWb),
        .retire(retire),
        .wbFwd(wbFwd)
    );

endmodule

`default_nettype wire

/* verilog/mipsPkg.sv */
// widths, opcodes, instruction union and pipeline stage records of the MIPS core
`default_nettype none

package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    // primary opcodes kept by this core
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opBeq     = 6'h04,
        opAddi    = 6'h08,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp_t;

    typedef struct packed {
        opcode_t  opcode;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        logic [4:0] shamt;
        funct_t   funct;
    } rInstr_t;

    typedef struct packed {
        opcode_t  opcode;
        regAddr_t rs;
        regAddr_t rt;
        logic [15:0] imm16;
    } iInstr_t;

    // one fetched word, seen as R-type or I-type
    typedef union packed {
        rInstr_t r;
        iInstr_t i;
    } instr_t;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   branch;
        logic   aluSrcImm;
        logic   regDstRd;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t dst;
        word_t    rsData;
        word_t    rtData;
        word_t    imm;
        word_t    branchTarget;
    } idEx_t;

    typedef struct packed {
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        word_t    aluResult;
        word_t    storeData;
        regAddr_t dst;
    } exMem_t;

    typedef struct packed {
        logic     regWrite;
        logic     memRead;
        word_t    aluResult;
        word_t    loadData;
        regAddr_t dst;
    } memWb_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  read;
        logic  write;
    } dmemReq_t;

    typedef struct packed {
        logic     valid;
        regAddr_t addr;
        word_t    value;
    } retire_t;

    typedef enum logic [1:0] {
        fwdReg,
        fwdExMem,
        fwdMemWb
    } fwdSel_t;

endpackage

`default_nettype wire

/* verilog/regFile.sv */
// 32-entry register file, two read ports with write bypass, zero register
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire  mipsPkg::regAddr_t rsAddr,
    input  wire  mipsPkg::regAddr_t rtAddr,
    input  wire  mipsPkg::retire_t  wb,
    output mipsPkg::word_t          rsData,
    output mipsPkg::word_t          rtData
);
    import mipsPkg::*;

    word_t regs [32];

    // r0 reads zero, a same-cycle write is seen at once
    function automatic word_t readPort(input regAddr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wb.valid && wb.addr == addr) begin
            value = wb.value;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.addr != '0) begin
            regs[wb.addr] <= wb.value;
        end
    end

    assign rsData = readPort(rsAddr);
    assign rtData = readPort(rtAddr);

endmodule

`default_nettype wire
